// ==== build.f ====
+incdir+src
+incdir+verification
src/cpu_types_pkg.sv
src/bus_types_pkg.sv
src/cache_ifs.sv
src/dcache.sv
src/icache.sv
src/memory_arbiter.sv
src/cache_subsystem.sv
verification/cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cache testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module cache_tb -f build.f -o Vcache_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vcache_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" "$LOG"; then
  exit 1
fi
exit 0

// ==== verification/cache_tb_tasks.svh ====
`ifndef CACHE_TB_TASKS_SVH
`define CACHE_TB_TASKS_SVH

// Reference cache state
logic              ref_valid [`DCACHE_SETS][`DCACHE_WAYS];
logic              ref_dirty [`DCACHE_SETS][`DCACHE_WAYS];
logic [DTAG_W-1:0] ref_tag [`DCACHE_SETS][`DCACHE_WAYS];
word_t             ref_data [`DCACHE_SETS][`DCACHE_WAYS][`DCACHE_BLOCK_WORDS];
logic              ref_lru [`DCACHE_SETS];
int                ref_score;
logic              iref_valid [`ICACHE_FRAMES];
logic [ITAG_W-1:0] iref_tag [`ICACHE_FRAMES];

function automatic word_t lcg_next();
  rng_state = rng_state * 32'd1103515245 + 32'd12345;
  return {16'd0, rng_state[30:15]};
endfunction

// Untouched words get a pattern of the full address
function automatic word_t mem_expected(word_t addr);
  if (mem.exists(addr))
    return mem[addr];
  return (addr ^ 32'd55) * 32'd1103515245 + 32'd12345;
endfunction

function automatic void ref_reset();
  for (int s = 0; s < `DCACHE_SETS; s++) begin
    ref_lru[s] = 1'b0;
    for (int w = 0; w < `DCACHE_WAYS; w++) begin
      ref_valid[s][w] = 1'b0;
      ref_dirty[s][w] = 1'b0;
    end
  end
  for (int f = 0; f < `ICACHE_FRAMES; f++)
    iref_valid[f] = 1'b0;
  ref_score = 0;
endfunction

task automatic check_word(input string name, input word_t expected, input word_t actual);
  if (expected !== actual) begin
    $display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
    errors++;
  end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
  if (expected !== actual) begin
    $display("error at %0t: %s expected %b, got %b", $time, name, expected, actual);
    errors++;
  end
endtask

task automatic check_log_entry(input int k, input logic we, input word_t adr, input word_t dat);
  if (k >= log_adr.size()) begin
    $display("error at %0t: bus log has no entry %0d", $time, k);
    errors++;
  end else begin
    check_bit("log wb_we", we, log_we[k]);
    check_word("log wb_adr", adr, log_adr[k]);
    if (we)
      check_word("log wb_wdata", dat, log_dat[k]);
  end
endtask

task automatic finish_test(input string name, input int err_before);
  tests_run++;
  if (errors > err_before) begin
    tests_failed++;
    $display("%s: %0d errors", name, errors - err_before);
  end else begin
    $display("%s: ok", name);
  end
endtask

task automatic d_access(input word_t addr, input logic write, input word_t wdata,
                        input logic log_check);
  dcache_addr_t a;
  int    way, victim, k;
  logic  exp_hit, first_hit, first, dirty_victim;
  word_t got;
  a = addr;
  exp_hit = 1'b0;
  way = 0;
  for (int w = 0; w < `DCACHE_WAYS; w++) begin
    if (ref_valid[a.idx][w] && ref_tag[a.idx][w] == a.tag) begin
      exp_hit = 1'b1;
      way = w;
    end
  end
  victim = !ref_valid[a.idx][0] ? 0 : (!ref_valid[a.idx][1] ? 1 : int'(ref_lru[a.idx]));
  dirty_victim = ref_valid[a.idx][victim] && ref_dirty[a.idx][victim];
  k = log_adr.size();
  @(negedge CLK);
  dmemaddr = addr;
  dmemstore = wdata;
  dmemREN = !write;
  dmemWEN = write;
  first = 1'b1;
  forever begin
    #3;
    if (first)
      first_hit = dhit;
    first = 1'b0;
    if (dhit) begin
      got = dmemload;
      break;
    end
    @(negedge CLK);
  end
  @(negedge CLK);
  dmemREN = 1'b0;
  dmemWEN = 1'b0;
  check_bit("dhit", exp_hit, first_hit);
  if (!exp_hit) begin
    ref_score--;
    if (log_check) begin
      if (dirty_victim) begin
        for (int b = 0; b < 2; b++)
          check_log_entry(k + b, 1'b1, {ref_tag[a.idx][victim], a.idx, 1'(b), 2'b00},
                          ref_data[a.idx][victim][b]);
        k += 2;
      end
      for (int b = 0; b < 2; b++)
        check_log_entry(k + b, 1'b0, {a.tag, a.idx, 1'(b), 2'b00}, '0);
      check_word("bus log size", word_t'(k + 2), word_t'(log_adr.size()));
    end
    way = victim;
    ref_valid[a.idx][way] = 1'b1;
    ref_dirty[a.idx][way] = 1'b0;
    ref_tag[a.idx][way] = a.tag;
    for (int b = 0; b < 2; b++)
      ref_data[a.idx][way][b] = mem_expected({a.tag, a.idx, 1'(b), 2'b00});
  end
  ref_score++;
  ref_lru[a.idx] = (way == 0);
  if (write) begin
    ref_data[a.idx][way][a.blkoff] = wdata;
    ref_dirty[a.idx][way] = 1'b1;
  end else begin
    check_word("dmemload", ref_data[a.idx][way][a.blkoff], got);
  end
endtask

task automatic i_fetch(input word_t addr);
  icache_addr_t a;
  logic  exp_hit, first_hit, first;
  word_t got;
  a = addr;
  exp_hit = iref_valid[a.idx] && iref_tag[a.idx] == a.tag;
  @(negedge CLK);
  imemaddr = addr;
  imemREN = 1'b1;
  first = 1'b1;
  forever begin
    #3;
    if (first)
      first_hit = ihit;
    first = 1'b0;
    if (ihit) begin
      got = imemload;
      break;
    end
    @(negedge CLK);
  end
  @(negedge CLK);
  imemREN = 1'b0;
  check_bit("ihit", exp_hit, first_hit);
  check_word("imemload", mem_expected(addr), got);
  iref_valid[a.idx] = 1'b1;
  iref_tag[a.idx] = a.tag;
endtask

task automatic test_reset_state();
  int e;
  e = errors;
  @(negedge CLK);
  #3;
  check_bit("dhit", 1'b0, dhit);
  check_bit("ihit", 1'b0, ihit);
  check_bit("flushed", 1'b0, flushed);
  check_bit("wb_cyc", 1'b0, wb_cyc);
  check_bit("wb_stb", 1'b0, wb_stb);
  finish_test("after reset", e);
endtask

task automatic test_read_miss_hit();
  int e, n;
  e = errors;
  d_access(32'h0000_0250, 1'b0, '0, 1'b1);
  n = log_adr.size();
  d_access(32'h0000_0254, 1'b0, '0, 1'b1);   // Same block
  check_word("bus log size", word_t'(n), word_t'(log_adr.size()));
  finish_test("data read miss then hit", e);
endtask

task automatic test_store_evict();
  int e;
  e = errors;
  d_access(32'h0000_0254, 1'b1, 32'hCAFE_0001, 1'b1);
  d_access(32'h0000_0290, 1'b0, '0, 1'b1);
  d_access(32'h0000_02D0, 1'b0, '0, 1'b1);   // Evicts the dirty block
  check_word("memory word 0x254", 32'hCAFE_0001, mem_expected(32'h0000_0254));
  d_access(32'h0000_1018, 1'b1, 32'h1234_5678, 1'b1);
  d_access(32'h0000_0294, 1'b1, 32'h0BAD_F00D, 1'b1);
  finish_test("store hit then eviction", e);
endtask

task automatic test_contention();
  int e;
  e = errors;
  fork
    d_access(32'h0000_2020, 1'b0, '0, 1'b0);
    begin
      i_fetch(32'h0000_0400);
      i_fetch(32'h0000_0404);
      i_fetch(32'h0000_0400);
    end
  join
  finish_test("instruction fetches under contention", e);
endtask

task automatic test_halt_flush();
  int e, k;
  e = errors;
  k = log_adr.size();
  @(negedge CLK);
  halt = 1'b1;
  do begin
    @(negedge CLK);
    #3;
  end while (!flushed);
  // Way 0 of every set before way 1
  for (int w = 0; w < `DCACHE_WAYS; w++) begin
    for (int s = 0; s < `DCACHE_SETS; s++) begin
      if (ref_valid[s][w] && ref_dirty[s][w]) begin
        for (int b = 0; b < 2; b++)
          check_log_entry(k + b, 1'b1, {ref_tag[s][w], 3'(s), 1'(b), 2'b00}, ref_data[s][w][b]);
        k += 2;
      end
    end
  end
  check_log_entry(k, 1'b1, `HIT_SCORE_ADDR, word_t'(ref_score));
  check_word("bus log size", word_t'(k + 1), word_t'(log_adr.size()));
  repeat (4) begin
    @(negedge CLK);
    #3;
    check_bit("flushed", 1'b1, flushed);
  end
  finish_test("halt and flush", e);
endtask

`endif

// ==== verification/cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module cache_tb;
  import cpu_types_pkg::*;
  import bus_types_pkg::*;

  localparam int NUM_TESTS = 5;
  localparam int CLK_NS    = 8;

  logic     CLK, nRST;
  logic     halt, dmemREN, dmemWEN, imemREN;
  word_t    dmemaddr, dmemstore, imemaddr;
  logic     dhit, flushed, ihit;
  word_t    dmemload, imemload;
  logic     wb_cyc, wb_stb, wb_we, wb_ack;
  wb_addr_t wb_adr;
  wb_data_t wb_wdata, wb_rdata;

  // Memory model state and bus log
  word_t mem [word_t];
  logic  log_we [$];
  word_t log_adr [$];
  word_t log_dat [$];
  word_t rng_state = 32'd55;
  int    ack_delay = -1;

  int errors, tests_run, tests_failed;

  `include "cache_tb_tasks.svh"

  cache_subsystem i_dut (.*);

  initial begin
    CLK = 1'b0;
    forever #(CLK_NS / 2) CLK = ~CLK;
  end

  // Wishbone slave, acks after 0 to 3 cycles
  always @(negedge CLK) begin
    if (wb_ack) begin
      wb_ack = 1'b0;
    end else if (wb_stb) begin
      if (ack_delay < 0)
        ack_delay = int'(lcg_next() % 4);
      if (ack_delay == 0) begin
        if (wb_we)
          mem[wb_adr] = wb_wdata;
        else
          wb_rdata = mem_expected(wb_adr);
        log_we.push_back(wb_we);
        log_adr.push_back(wb_adr);
        log_dat.push_back(wb_we ? wb_wdata : wb_rdata);
        wb_ack    = 1'b1;
        ack_delay = -1;
      end else begin
        ack_delay--;
      end
    end
  end

  // Handshake monitor, sampled late in each cycle
  logic     prev_stb, prev_ack, prev_we;
  wb_addr_t prev_adr;
  initial begin
    prev_stb = 1'b0;
    prev_ack = 1'b0;
    prev_we  = 1'b0;
    prev_adr = '0;
  end
  always @(negedge CLK) begin
    #3;
    if (nRST) begin
      if (wb_stb && !wb_cyc) begin
        $display("error at %0t: strobe raised without cycle", $time);
        errors++;
      end
      if (prev_stb && !prev_ack && !(wb_stb && wb_adr == prev_adr && wb_we == prev_we)) begin
        $display("error at %0t: bus request changed before ack", $time);
        errors++;
      end
      if (prev_ack && wb_stb) begin
        $display("error at %0t: strobe did not drop after ack", $time);
        errors++;
      end
    end
    prev_stb = wb_stb;
    prev_ack = wb_ack;
    prev_we  = wb_we;
    prev_adr = wb_adr;
  end

  initial begin
    #(NUM_TESTS * 200 * CLK_NS);
    $display("watchdog: the tests did not finish in time, stopping the run");
    $display("test failed");
    $finish;
  end

  initial begin
    nRST = 1'b0;
    halt = 1'b0;
    dmemREN = 1'b0;
    dmemWEN = 1'b0;
    imemREN = 1'b0;
    dmemaddr = '0;
    dmemstore = '0;
    imemaddr = '0;
    wb_ack = 1'b0;
    wb_rdata = '0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    ref_reset();
    repeat (5) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;

    test_reset_state();
    test_read_miss_hit();
    test_store_evict();
    test_contention();
    test_halt_flush();

    $display("tests run %0d, failing tests %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/cache_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_subsystem (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    halt,
  input  logic                    dmemREN,
  input  logic                    dmemWEN,
  input  cpu_types_pkg::word_t    dmemaddr,
  input  cpu_types_pkg::word_t    dmemstore,
  output logic                    dhit,
  output cpu_types_pkg::word_t    dmemload,
  output logic                    flushed,
  input  logic                    imemREN,
  input  cpu_types_pkg::word_t    imemaddr,
  output logic                    ihit,
  output cpu_types_pkg::word_t    imemload,
  output logic                    wb_cyc,
  output logic                    wb_stb,
  output logic                    wb_we,
  output bus_types_pkg::wb_addr_t wb_adr,
  output bus_types_pkg::wb_data_t wb_wdata,
  input  bus_types_pkg::wb_data_t wb_rdata,
  input  logic                    wb_ack
);

  datapath_cache_if dcif ();
  icache_dp_if      icif ();
  caches_if         dmem ();
  caches_if         imem ();

  // Datapath side
  assign dcif.halt      = halt;
  assign dcif.dmemREN   = dmemREN;
  assign dcif.dmemWEN   = dmemWEN;
  assign dcif.dmemaddr  = dmemaddr;
  assign dcif.dmemstore = dmemstore;
  assign dhit           = dcif.dhit;
  assign dmemload       = dcif.dmemload;
  assign flushed        = dcif.flushed;

  assign icif.imemREN   = imemREN;
  assign icif.imemaddr  = imemaddr;
  assign ihit           = icif.ihit;
  assign imemload       = icif.imemload;

  dcache i_dcache (
    .CLK  (CLK),
    .nRST (nRST),
    .dcif (dcif),
    .cif  (dmem)
  );

  icache i_icache (
    .CLK  (CLK),
    .nRST (nRST),
    .icif (icif),
    .cif  (imem)
  );

  memory_arbiter i_arbiter (
    .CLK      (CLK),
    .nRST     (nRST),
    .dport    (dmem),
    .iport    (imem),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_wdata (wb_wdata),
    .wb_rdata (wb_rdata),
    .wb_ack   (wb_ack)
  );

endmodule

`default_nettype wire

// ==== src/memory_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory_arbiter (
  input  logic                    CLK,
  input  logic                    nRST,
  caches_if.arbiter               dport,
  caches_if.arbiter               iport,
  output logic                    wb_cyc,
  output logic                    wb_stb,
  output logic                    wb_we,
  output bus_types_pkg::wb_addr_t wb_adr,
  output bus_types_pkg::wb_data_t wb_wdata,
  input  bus_types_pkg::wb_data_t wb_rdata,
  input  logic                    wb_ack
);
  import bus_types_pkg::*;

  arb_owner_t owner, next_owner;
  logic d_req, i_req;

  assign d_req = dport.REN || dport.WEN;
  assign i_req = iport.REN || iport.WEN;

  // Grants only while idle with the data side first
  always_comb begin
    next_owner = owner;
    if (owner == OWN_NONE) begin
      if (d_req)
        next_owner = OWN_D;
      else if (i_req)
        next_owner = OWN_I;
    end else if (wb_ack) begin
      next_owner = OWN_NONE;   // One idle clock after each word
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST)
      owner <= OWN_NONE;
    else
      owner <= next_owner;
  end

  assign wb_cyc = (owner != OWN_NONE);
  assign wb_stb = wb_cyc;

  // Owner holds its request stable until ack
  always_comb begin
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_wdata = '0;
    case (owner)
      OWN_D: begin
        wb_we    = dport.WEN;
        wb_adr   = dport.addr;
        wb_wdata = dport.store;
      end
      OWN_I: begin
        wb_we    = iport.WEN;
        wb_adr   = iport.addr;
        wb_wdata = iport.store;
      end
      default: wb_we = 1'b0;
    endcase
  end

  assign dport.mem_wait = !(owner == OWN_D && wb_ack);
  assign iport.mem_wait = !(owner == OWN_I && wb_ack);
  assign dport.load     = wb_rdata;
  assign iport.load     = wb_rdata;

  a_owner_requests: assert property (@(posedge CLK) disable iff (!nRST)
    wb_stb && !wb_ack |-> ((owner == OWN_D) ? d_req : i_req));

  a_req_stable: assert property (@(posedge CLK) disable iff (!nRST)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we));

endmodule

`default_nettype wire

// ==== src/icache.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module icache (
  input logic         CLK,
  input logic         nRST,
  icache_dp_if.icache icif,
  caches_if.cache     cif
);
  import cpu_types_pkg::*;

  typedef enum logic {IDLE, FETCH} ic_state_t;

  ic_state_t state, next_state;
  icache_frame [`ICACHE_FRAMES-1:0] frames;
  cache_addr_u req;
  icache_frame cur;
  logic        match;

  assign req.raw = icif.imemaddr;
  assign cur     = frames[req.ic.idx];
  assign match   = cur.valid && (cur.tag == req.ic.tag);

  assign icif.ihit     = (state == IDLE) && icif.imemREN && match;
  assign icif.imemload = cur.data;

  // Read only with one word per frame
  assign cif.REN   = (state == FETCH);
  assign cif.WEN   = 1'b0;
  assign cif.addr  = {req.ic.tag, req.ic.idx, {BYTOFF_W{1'b0}}};
  assign cif.store = '0;

  always_comb begin
    next_state = state;
    case (state)
      IDLE:    if (icif.imemREN && !match) next_state = FETCH;
      FETCH:   if (!cif.mem_wait) next_state = IDLE;
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state  <= IDLE;
      frames <= '0;
    end else begin
      state <= next_state;
      if (state == FETCH && !cif.mem_wait) begin
        frames[req.ic.idx].valid <= 1'b1;
        frames[req.ic.idx].tag   <= req.ic.tag;
        frames[req.ic.idx].data  <= cif.load;
      end
    end
  end

  a_fetch_held: assert property (@(posedge CLK) disable iff (!nRST)
    cif.REN && cif.mem_wait |=> cif.REN && $stable(cif.addr));

endmodule

`default_nettype wire

// ==== src/dcache.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module dcache (
  input logic              CLK,
  input logic              nRST,
  datapath_cache_if.dcache dcif,
  caches_if.cache          cif
);
  import cpu_types_pkg::*;

  typedef enum logic [3:0] {
    IDLE, WB0, WB1, LOAD0, LOAD1, FLUSH, WRITE0, WRITE1, SCORE, HALTED
  } dc_state_t;

  dc_state_t state, next_state;
  dcache_frame [`DCACHE_SETS-1:0][`DCACHE_WAYS-1:0] frames, next_frames;
  logic [`DCACHE_SETS-1:0] lru, next_lru;        // Way to replace next
  logic [DIDX_W+1:0] flush_cnt, next_flush_cnt;  // {done, way, set}
  logic signed [WORD_W-1:0] hit_score, next_hit_score;

  cache_addr_u       req;
  logic [DIDX_W-1:0] idx;
  logic [DIDX_W-1:0] flush_set;
  logic              flush_way;
  logic              hit, hit_way, victim;
  dcache_frame       victim_frame, flush_frame;

  function automatic word_t blk_addr(logic [DTAG_W-1:0] tag, logic [DIDX_W-1:0] set,
                                     logic [DBLK_W-1:0] blk);
    cache_addr_u a;
    a.dc.tag    = tag;
    a.dc.idx    = set;
    a.dc.blkoff = blk;
    a.dc.bytoff = '0;
    return a.raw;
  endfunction

  assign req.raw      = dcif.dmemaddr;
  assign idx          = req.dc.idx;
  assign flush_set    = flush_cnt[DIDX_W-1:0];
  assign flush_way    = flush_cnt[DIDX_W];
  assign flush_frame  = frames[flush_set][flush_way];
  assign victim_frame = frames[idx][victim];

  // Tag compare on both ways
  always_comb begin
    hit     = 1'b0;
    hit_way = 1'b0;
    for (int w = 0; w < `DCACHE_WAYS; w++) begin
      if (frames[idx][w].valid && frames[idx][w].tag == req.dc.tag) begin
        hit     = 1'b1;
        hit_way = 1'(w);
      end
    end
  end

  // Prefer an empty way over the LRU way
  always_comb begin
    if (!frames[idx][0].valid)
      victim = 1'b0;
    else if (!frames[idx][1].valid)
      victim = 1'b1;
    else
      victim = lru[idx];
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state     <= IDLE;
      frames    <= '0;
      lru       <= '0;
      flush_cnt <= '0;
      hit_score <= '0;
    end else begin
      state     <= next_state;
      frames    <= next_frames;
      lru       <= next_lru;
      flush_cnt <= next_flush_cnt;
      hit_score <= next_hit_score;
    end
  end

  always_comb begin
    next_state     = state;
    next_frames    = frames;
    next_lru       = lru;
    next_flush_cnt = flush_cnt;
    next_hit_score = hit_score;
    dcif.dhit      = 1'b0;
    dcif.dmemload  = '0;
    dcif.flushed   = 1'b0;
    cif.REN        = 1'b0;
    cif.WEN        = 1'b0;
    cif.addr       = '0;
    cif.store      = '0;

    case (state)
      IDLE: begin
        if (dcif.halt) begin
          next_state = FLUSH;
        end else if (dcif.dmemREN || dcif.dmemWEN) begin
          if (hit) begin
            dcif.dhit      = 1'b1;
            next_hit_score = hit_score + 1;
            next_lru[idx]  = ~hit_way;
            if (dcif.dmemWEN) begin
              next_frames[idx][hit_way].data[req.dc.blkoff] = dcif.dmemstore;
              next_frames[idx][hit_way].dirty = 1'b1;
            end else begin
              dcif.dmemload = frames[idx][hit_way].data[req.dc.blkoff];
            end
          end else begin
            next_hit_score = hit_score - 1;
            next_state = (victim_frame.valid && victim_frame.dirty) ? WB0 : LOAD0;
          end
        end
      end

      WB0, WB1: begin
        cif.WEN   = 1'b1;
        cif.addr  = blk_addr(victim_frame.tag, idx, DBLK_W'(state == WB1));
        cif.store = victim_frame.data[state == WB1];
        if (!cif.mem_wait) begin
          next_state = (state == WB1) ? LOAD0 : WB1;
          if (state == WB1) begin
            next_frames[idx][victim].valid = 1'b0;
            next_frames[idx][victim].dirty = 1'b0;
          end
        end
      end

      // Victim frame goes invalid after word 0 and keeps the way choice
      LOAD0, LOAD1: begin
        cif.REN  = 1'b1;
        cif.addr = blk_addr(req.dc.tag, idx, DBLK_W'(state == LOAD1));
        if (!cif.mem_wait) begin
          next_frames[idx][victim].data[state == LOAD1] = cif.load;
          next_frames[idx][victim].valid = (state == LOAD1);
          next_frames[idx][victim].dirty = 1'b0;
          next_frames[idx][victim].tag   = req.dc.tag;
          next_state = (state == LOAD1) ? IDLE : LOAD1;
        end
      end

      FLUSH: begin
        if (flush_cnt[DIDX_W+1])
          next_state = SCORE;
        else if (flush_frame.valid && flush_frame.dirty)
          next_state = WRITE0;
        else
          next_flush_cnt = flush_cnt + 1'b1;   // Skip a clean frame
      end

      WRITE0, WRITE1: begin
        cif.WEN   = 1'b1;
        cif.addr  = blk_addr(flush_frame.tag, flush_set, DBLK_W'(state == WRITE1));
        cif.store = flush_frame.data[state == WRITE1];
        if (!cif.mem_wait) begin
          next_state = (state == WRITE1) ? FLUSH : WRITE1;
          if (state == WRITE1) begin
            next_frames[flush_set][flush_way].valid = 1'b0;
            next_frames[flush_set][flush_way].dirty = 1'b0;
            next_flush_cnt = flush_cnt + 1'b1;
          end
        end
      end

      SCORE: begin
        cif.WEN   = 1'b1;
        cif.addr  = `HIT_SCORE_ADDR;
        cif.store = hit_score;
        if (!cif.mem_wait)
          next_state = HALTED;
      end

      HALTED: dcif.flushed = 1'b1;   // Held until reset

      default: next_state = IDLE;
    endcase
  end

  // Memory request stays put until the word moves
  a_req_held: assert property (@(posedge CLK) disable iff (!nRST)
    (cif.REN || cif.WEN) && cif.mem_wait |=>
      $stable(cif.REN) && $stable(cif.WEN) && $stable(cif.addr) && $stable(cif.store));

endmodule

`default_nettype wire

// ==== src/cache_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

interface datapath_cache_if;
  import cpu_types_pkg::*;

  logic  halt, dmemREN, dmemWEN;
  word_t dmemaddr, dmemstore;
  logic  dhit, flushed;
  word_t dmemload;

  modport dcache (
    input  halt, dmemREN, dmemWEN, dmemaddr, dmemstore,
    output dhit, dmemload, flushed
  );
  modport datapath (
    output halt, dmemREN, dmemWEN, dmemaddr, dmemstore,
    input  dhit, dmemload, flushed
  );
endinterface

interface icache_dp_if;
  import cpu_types_pkg::*;

  logic  imemREN, ihit;
  word_t imemaddr, imemload;

  modport icache (input imemREN, imemaddr, output ihit, imemload);
  modport datapath (output imemREN, imemaddr, input ihit, imemload);
endinterface

interface caches_if;
  import cpu_types_pkg::*;

  logic  REN, WEN;
  word_t addr, store;
  logic  mem_wait;   // High until the word is moved
  word_t load;

  modport cache (output REN, WEN, addr, store, input mem_wait, load);
  modport arbiter (input REN, WEN, addr, store, output mem_wait, load);
endinterface

`default_nettype wire

// ==== src/bus_types_pkg.sv ====
`default_nettype none
`include "cache_macros.svh"

package bus_types_pkg;

  // Which cache owns the current Wishbone cycle
  typedef enum logic [1:0] {
    OWN_NONE,
    OWN_D,
    OWN_I
  } arb_owner_t;

  typedef logic [`WORD_BITS-1:0] wb_addr_t;
  typedef logic [`WORD_BITS-1:0] wb_data_t;

endpackage

`default_nettype wire

// ==== src/cpu_types_pkg.sv ====
`default_nettype none
`include "cache_macros.svh"

package cpu_types_pkg;

  localparam int WORD_W   = `WORD_BITS;
  localparam int BYTOFF_W = $clog2(`WORD_BITS / 8);
  localparam int DIDX_W   = $clog2(`DCACHE_SETS);
  localparam int DBLK_W   = $clog2(`DCACHE_BLOCK_WORDS);
  localparam int DTAG_W   = WORD_W - DIDX_W - DBLK_W - BYTOFF_W;
  localparam int IIDX_W   = $clog2(`ICACHE_FRAMES);
  localparam int ITAG_W   = WORD_W - IIDX_W - BYTOFF_W;

  typedef logic [WORD_W-1:0] word_t;

  typedef struct packed {
    logic [DTAG_W-1:0]   tag;
    logic [DIDX_W-1:0]   idx;
    logic [DBLK_W-1:0]   blkoff;
    logic [BYTOFF_W-1:0] bytoff;
  } dcache_addr_t;

  typedef struct packed {
    logic [ITAG_W-1:0]   tag;
    logic [IIDX_W-1:0]   idx;
    logic [BYTOFF_W-1:0] bytoff;
  } icache_addr_t;

  // Same address word, one view per cache
  typedef union packed {
    word_t        raw;
    dcache_addr_t dc;
    icache_addr_t ic;
  } cache_addr_u;

  typedef struct packed {
    logic                                valid;
    logic                                dirty;
    logic [DTAG_W-1:0]                   tag;
    word_t [`DCACHE_BLOCK_WORDS-1:0]     data;
  } dcache_frame;

  typedef struct packed {
    logic              valid;
    logic [ITAG_W-1:0] tag;
    word_t             data;
  } icache_frame;

endpackage

`default_nettype wire

// ==== src/cache_macros.svh ====
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Data cache organization
`define DCACHE_SETS         8
`define DCACHE_WAYS         2
`define DCACHE_BLOCK_WORDS  2

// Instruction cache organization
`define ICACHE_FRAMES       16

`define WORD_BITS           32

// Flush writes the signed hit score here
`define HIT_SCORE_ADDR      32'h3100

`endif
